// ==== build.f ====
hdl/sdramFsmPkg.sv
hdl/sdramBusIf.sv
hdl/seqProgressIf.sv
hdl/writeSequencer.sv
hdl/readVerifier.sv
hdl/demoSdram.sv
hdl/sdramFsmTop.sv
verification/sdramFsmTb.sv

// ==== hdl/demoSdram.sv ====
`timescale 1ns/1ps

module demoSdram (
    input  logic      Clock,
    input  logic      rstN,
    sdramBusIf.memory bus
);
    import sdramFsmPkg::*;

    dataT memArray [MEM_DEPTH];     // stand in for the real device

    // ------------------------------
    // arbitration
    // ------------------------------
    // writes always win, a read waits for a free cycle
    assign bus.rdGrant = bus.rdRequest && !bus.wrRequest;

    // ------------------------------
    // array and read data
    // ------------------------------
    always_ff @(posedge Clock) begin
        if (bus.wrRequest)
            memArray[bus.writeAddress] <= bus.writeData;
        if (bus.rdGrant)
            bus.readData <= memArray[bus.readAddress];  // one cycle after grant
    end

    always_ff @(posedge Clock) begin
        if (!rstN)
            bus.readValid <= 1'b0;
        else
            bus.readValid <= bus.rdGrant;               // marks the registered word
    end

    // a waiting read keeps its request and address until granted
    holdUntilGrant: assert property (@(posedge Clock) disable iff (!rstN)
        (bus.rdRequest && !bus.rdGrant) |=> (bus.rdRequest && $stable(bus.readAddress)));

endmodule

// ==== hdl/readVerifier.sv ====
`timescale 1ns/1ps

module readVerifier (
    input  logic                Clock,
    input  logic                rstN,
    sdramBusIf.reader           bus,
    seqProgressIf.sink          progress,
    output logic                Busy,
    output logic                Done,
    output sdramFsmPkg::countT  MismatchCount,
    output sdramFsmPkg::addrT   ReadAddress
);
    import sdramFsmPkg::*;

    typedef enum logic [1:0] {idle, request, waitData, finish} verifyStateT;

    verifyStateT state;
    addrT readAddress;          // address requested and then returning
    byteT baseLatch;
    logic wordReady;            // requested word already written
    logic lastWord;
    logic mismatch;

    // ------------------------------
    // status decode
    // ------------------------------
    assign wordReady = progress.writtenCount > {1'b0, readAddress};
    assign lastWord  = ({1'b0, readAddress} + 7'd1) == progress.wordTotal;
    assign mismatch  = bus.readData != patternWord(baseLatch, readAddress);

    assign bus.rdRequest   = (state == request) && wordReady;   // held until granted
    assign bus.readAddress = readAddress;
    assign ReadAddress     = readAddress;

    // busy from the runStart cycle, low again with Done
    assign Busy = progress.runStart || (state == request) || (state == waitData);
    assign Done = (state == finish);

    // ------------------------------
    // read back FSM
    // ------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state         <= idle;
            readAddress   <= '0;
            MismatchCount <= '0;
        end else begin
            case (state)
                idle: begin
                    if (progress.runStart) begin
                        baseLatch     <= progress.patternBase;
                        readAddress   <= '0;
                        MismatchCount <= '0;    // cleared per run, kept after Done
                        state         <= request;
                    end
                end
                request: begin
                    if (bus.rdGrant)
                        state <= waitData;
                end
                waitData: begin
                    if (bus.readValid) begin
                        if (mismatch)
                            MismatchCount <= MismatchCount + 7'd1;
                        if (lastWord) begin
                            state <= finish;
                        end else begin
                            readAddress <= readAddress + 6'd1;
                            state       <= request;
                        end
                    end
                end
                finish: state <= idle;          // Done for this one cycle
                default: state <= idle;
            endcase
        end
    end

    // data only comes back for a request this block made
    validAfterGrant: assert property (@(posedge Clock) disable iff (!rstN)
        bus.readValid |-> $past(bus.rdGrant && bus.rdRequest && (state == request)));

endmodule

// ==== hdl/sdramBusIf.sv ====
`timescale 1ns/1ps

interface sdramBusIf;
    import sdramFsmPkg::*;

    // ------------------------------
    // write side, from the writer
    // ------------------------------
    logic wrRequest;        // word written at this edge, no wait
    addrT writeAddress;
    dataT writeData;

    // ------------------------------
    // read side
    // ------------------------------
    logic rdRequest;        // held with readAddress until rdGrant
    addrT readAddress;
    logic rdGrant;          // only in a cycle without wrRequest
    dataT readData;         // valid with readValid
    logic readValid;        // one cycle after rdGrant

    // writer watches readValid to know when the run has drained
    modport writer (
        output wrRequest, writeAddress, writeData,
        input  readValid
    );

    modport reader (
        output rdRequest, readAddress,
        input  rdGrant, readData, readValid
    );

    modport memory (
        input  wrRequest, writeAddress, writeData, rdRequest, readAddress,
        output rdGrant, readData, readValid
    );

endinterface

// ==== hdl/sdramFsmPkg.sv ====
package sdramFsmPkg;

    // ------------------------------
    // sizes of the demo memory
    // ------------------------------
    localparam int DATA_WIDTH = 16;                 // one memory word
    localparam int ADDR_WIDTH = 6;                  // 64 word demo array
    localparam int MEM_DEPTH  = 1 << ADDR_WIDTH;

    typedef logic [DATA_WIDTH-1:0] dataT;           // two segment codes per word
    typedef logic [ADDR_WIDTH-1:0] addrT;
    typedef logic [ADDR_WIDTH:0]   countT;          // 1 to 64 needs one extra bit
    typedef logic [7:0]            byteT;           // pattern base
    typedef logic [6:0]            segT;            // segments g..a, active high

    // hex digit to segment code
    function automatic segT sevenSegOf(input logic [3:0] digit);
        segT seg;
        case (digit)
            4'h0: seg = 7'h3F;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5B;
            4'h3: seg = 7'h4F;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6D;
            4'h6: seg = 7'h7D;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7F;
            4'h9: seg = 7'h6F;
            4'hA: seg = 7'h77;
            4'hB: seg = 7'h7C;                      // lower case b
            4'hC: seg = 7'h39;
            4'hD: seg = 7'h5E;                      // lower case d
            4'hE: seg = 7'h79;
            default: seg = 7'h71;                   // F
        endcase
        return seg;
    endfunction

    // word stored at addr for a run with base
    function automatic dataT patternWord(input byteT base, input addrT addr);
        byteT value;
        value = base + byteT'(addr);                // wraps modulo 256
        return {1'b0, sevenSegOf(value[7:4]), 1'b0, sevenSegOf(value[3:0])};
    endfunction

endpackage

// ==== hdl/sdramFsmTop.sv ====
`timescale 1ns/1ps

module sdramFsmTop (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               StartWr,         // ignored while Busy
    input  sdramFsmPkg::countT WordCount,       // 1 to 64
    input  sdramFsmPkg::byteT  PatternBase,
    output logic               Busy,
    output logic               Done,
    output sdramFsmPkg::countT MismatchCount,
    output sdramFsmPkg::dataT  ReadData,
    output logic               ReadValid,
    output sdramFsmPkg::addrT  ReadAddress
);

    sdramBusIf    sdramBus ();
    seqProgressIf progressLink ();

    // ------------------------------
    // pattern writer
    // ------------------------------
    writeSequencer writeSeq (
        .Clock       (Clock),
        .rstN        (rstN),
        .StartWr     (StartWr),
        .WordCount   (WordCount),
        .PatternBase (PatternBase),
        .bus         (sdramBus.writer),
        .progress    (progressLink.source)
    );

    // ------------------------------
    // read back and compare
    // ------------------------------
    readVerifier verifier (
        .Clock         (Clock),
        .rstN          (rstN),
        .bus           (sdramBus.reader),
        .progress      (progressLink.sink),
        .Busy          (Busy),
        .Done          (Done),
        .MismatchCount (MismatchCount),
        .ReadAddress   (ReadAddress)
    );

    demoSdram sdram (
        .Clock (Clock),
        .rstN  (rstN),
        .bus   (sdramBus.memory)
    );

    assign ReadData  = sdramBus.readData;    // word under ReadAddress
    assign ReadValid = sdramBus.readValid;

endmodule

// ==== hdl/seqProgressIf.sv ====
`timescale 1ns/1ps

interface seqProgressIf;
    import sdramFsmPkg::*;

    // all driven by the write sequencer
    logic  runStart;        // one cycle pulse per accepted start
    countT wordTotal;       // words in this run, held for the whole run
    byteT  patternBase;     // base of the pattern, held for the whole run
    countT writtenCount;    // words already in memory

    // ------------------------------
    // writer end
    // ------------------------------
    modport source (
        output runStart, wordTotal, patternBase, writtenCount
    );

    // ------------------------------
    // verifier end
    // ------------------------------
    modport sink (
        input runStart, wordTotal, patternBase, writtenCount
    );

endinterface

// ==== hdl/writeSequencer.sv ====
`timescale 1ns/1ps

module writeSequencer (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               StartWr,
    input  sdramFsmPkg::countT WordCount,
    input  sdramFsmPkg::byteT  PatternBase,
    sdramBusIf.writer          bus,
    seqProgressIf.source       progress
);
    import sdramFsmPkg::*;

    typedef enum logic {idle, writing} writerStateT;

    writerStateT state;
    logic  runStart;
    countT wordTotal;
    byteT  patternBase;
    addrT  writeAddress;
    countT writtenCount;
    countT returnedCount;       // words read back so far
    logic  writesLeft;

    assign writesLeft = writtenCount < wordTotal;

    // ------------------------------
    // bus and progress outputs
    // ------------------------------
    assign bus.wrRequest    = (state == writing) && writesLeft;
    assign bus.writeAddress = writeAddress;
    assign bus.writeData    = patternWord(patternBase, writeAddress);

    assign progress.runStart     = runStart;
    assign progress.wordTotal    = wordTotal;
    assign progress.patternBase  = patternBase;
    assign progress.writtenCount = writtenCount;

    // writing covers the whole run, writes first and then the read back
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state         <= idle;
            runStart      <= 1'b0;
            wordTotal     <= '0;
            writeAddress  <= '0;
            writtenCount  <= '0;
            returnedCount <= '0;
        end else begin
            runStart <= 1'b0;                       // single cycle pulse
            case (state)
                idle: begin
                    if (StartWr && (WordCount != '0)) begin   // zero length start dropped
                        wordTotal     <= WordCount;
                        patternBase   <= PatternBase;
                        writeAddress  <= '0;
                        writtenCount  <= '0;
                        returnedCount <= '0;
                        runStart      <= 1'b1;
                        state         <= writing;
                    end
                end
                writing: begin
                    if (writesLeft) begin           // one word every cycle, writes never stall
                        writeAddress <= writeAddress + 6'd1;
                        writtenCount <= writtenCount + 7'd1;
                    end
                    if (bus.readValid) begin
                        returnedCount <= returnedCount + 7'd1;
                        if ((returnedCount + 7'd1) == wordTotal)
                            state <= idle;          // same edge the verifier finishes
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // write address stays inside the run
    writeInRun: assert property (@(posedge Clock) disable iff (!rstN)
        bus.wrRequest |-> ({1'b0, bus.writeAddress} < progress.wordTotal));

endmodule

// ==== verification/sdramFsmTb.sv ====
`timescale 1ns/1ps

module sdramFsmTb;
    import sdramFsmPkg::*;

    localparam int RUN_COUNT  = 6;
    localparam int WAIT_LIMIT = 500;     // cycles per wait, a full 64 word run needs about 200
    localparam int IDLE_WATCH = 20;      // cycles watched after an ignored start

    logic  Clock;
    logic  rstN;
    logic  StartWr;
    countT WordCount;
    byteT  PatternBase;
    logic  Busy;
    logic  Done;
    countT MismatchCount;
    dataT  ReadData;
    logic  ReadValid;
    addrT  ReadAddress;

    int     errorCount;
    int     timeoutCount;
    integer seed;
    bit     busySeen;

    // ------------------------------
    // run table
    // ------------------------------
    // words, base, run expected, mismatches expected at Done
    countT runWords    [RUN_COUNT] = '{7'd64, 7'd1, 7'd10, 7'd37, 7'd64, 7'd0};
    byteT  runBase     [RUN_COUNT] = '{8'h00, 8'hFF, 8'h30, 8'hC8, 8'h5A, 8'h11};
    bit    runExpected [RUN_COUNT] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
    countT runMismatch [RUN_COUNT] = '{7'd0, 7'd0, 7'd0, 7'd0, 7'd0, 7'd0};

    // segments g..a per hex digit
    logic [6:0] segTable [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    sdramFsmTop dut_i (
        .Clock         (Clock),
        .rstN          (rstN),
        .StartWr       (StartWr),
        .WordCount     (WordCount),
        .PatternBase   (PatternBase),
        .Busy          (Busy),
        .Done          (Done),
        .MismatchCount (MismatchCount),
        .ReadData      (ReadData),
        .ReadValid     (ReadValid),
        .ReadAddress   (ReadAddress)
    );

    initial Clock = 1'b0;
    always #10 Clock = ~Clock;           // 20 ns period

    // expected word, two segment codes of (base + addr) mod 256
    function automatic dataT expectedWord(input byteT base, input int addr);
        logic [7:0] value;
        value = base + 8'(addr);         // byte add wraps
        return {1'b0, segTable[value[7:4]], 1'b0, segTable[value[3:0]]};
    endfunction

    // one cycle start pulse
    task automatic pulseStart(input countT words, input byteT base);
        @(posedge Clock);
        StartWr     <= 1'b1;
        WordCount   <= words;
        PatternBase <= base;
        @(posedge Clock);
        StartWr <= 1'b0;
    endtask

    task automatic waitForBusy(input int row, output bit ok);
        int cycles;
        ok = 1'b0;
        for (cycles = 0; cycles < WAIT_LIMIT && !ok; cycles++) begin
            @(negedge Clock);
            if (Busy)
                ok = 1'b1;
        end
        if (!ok) begin
            $display("timeout: Busy never rose for run %0d", row);
            timeoutCount++;
        end
    endtask

    // ------------------------------
    // one run, word by word
    // ------------------------------
    task automatic followRun(input int row);
        bit seen [MEM_DEPTH];
        int seenCount;
        int cycles;
        int strayCycle;
        bit strayActive;
        bit finished;
        seenCount   = 0;
        strayActive = 1'b0;
        finished    = 1'b0;
        strayCycle  = 1 + ($unsigned($random(seed)) % 2);   // early, before any run can end
        foreach (seen[i])
            seen[i] = 1'b0;
        for (cycles = 0; cycles < WAIT_LIMIT && !finished; cycles++) begin
            @(negedge Clock);
            if (ReadValid) begin
                if (ReadAddress >= runWords[row]) begin
                    $display("ERR %0t: run %0d address %0d outside the run", $time, row,
                             ReadAddress);
                    errorCount++;
                end else if (seen[ReadAddress]) begin
                    $display("ERR %0t: run %0d address %0d read twice", $time, row,
                             ReadAddress);
                    errorCount++;
                end else begin
                    seen[ReadAddress] = 1'b1;
                end
                if (ReadData !== expectedWord(runBase[row], ReadAddress)) begin
                    $display("ERR %0t: run %0d addr %0d data %h expected %h", $time, row,
                             ReadAddress, ReadData, expectedWord(runBase[row], ReadAddress));
                    errorCount++;
                end
                seenCount++;
            end
            if (Done) begin
                finished = 1'b1;
                if (seenCount != runWords[row]) begin
                    $display("ERR %0t: run %0d returned %0d words expected %0d", $time, row,
                             seenCount, runWords[row]);
                    errorCount++;
                end
                if (MismatchCount !== runMismatch[row]) begin
                    $display("ERR %0t: run %0d MismatchCount %0d expected %0d", $time, row,
                             MismatchCount, runMismatch[row]);
                    errorCount++;
                end
                if (Busy !== 1'b0) begin
                    $display("ERR %0t: run %0d Busy still high with Done", $time, row);
                    errorCount++;
                end
            end
            if (strayActive) begin
                @(posedge Clock);
                StartWr     <= 1'b0;             // stray start seen at one edge only
                strayActive = 1'b0;
            end else if (cycles == strayCycle && Busy && !ReadValid && !Done) begin
                @(posedge Clock);
                StartWr     <= 1'b1;             // must be ignored, run in progress
                WordCount   <= 7'd5;
                PatternBase <= 8'hEE;
                strayActive = 1'b1;
            end
        end
        if (!finished) begin
            $display("timeout: run %0d never reached Done", row);
            timeoutCount++;
        end else begin
            @(negedge Clock);
            if (Done !== 1'b0 || Busy !== 1'b0) begin
                $display("ERR %0t: run %0d Done %b Busy %b after the Done cycle", $time,
                         row, Done, Busy);
                errorCount++;
            end
        end
    endtask

    // zero length start, nothing may happen
    task automatic watchIdle(input int row);
        int cycles;
        for (cycles = 0; cycles < IDLE_WATCH; cycles++) begin
            @(negedge Clock);
            if (Busy !== 1'b0 || Done !== 1'b0 || ReadValid !== 1'b0) begin
                $display("ERR %0t: run %0d ignored start still gave Busy %b Done %b", $time,
                         row, Busy, Done);
                errorCount++;
            end
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rstN         = 1'b0;
        StartWr      = 1'b0;
        WordCount    = '0;
        PatternBase  = '0;
        errorCount   = 0;
        timeoutCount = 0;
        seed         = 32'hb9a3b70c;
        repeat (16) @(posedge Clock);
        rstN <= 1'b1;
        @(negedge Clock);
        if (Busy !== 1'b0 || Done !== 1'b0 || ReadValid !== 1'b0) begin
            $display("ERR %0t: after reset Busy %b Done %b ReadValid %b", $time, Busy, Done,
                     ReadValid);
            errorCount++;
        end
        for (int row = 0; row < RUN_COUNT; row++) begin
            pulseStart(runWords[row], runBase[row]);
            if (runExpected[row]) begin
                waitForBusy(row, busySeen);
                if (busySeen)
                    followRun(row);
            end else begin
                watchIdle(row);
            end
        end
        $display("closing report: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
